/* stack_up_pkg.sv */
// Upstream stack bus definitions
// Bus widths, frame codes, packet types and the beat record

package stack_up_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int UP_DATA_WIDTH = 64;
  localparam int UP_TAG_WIDTH  = 16;  // Out-of-band tag

  // Frame code of each beat
  typedef enum logic [1:0] {
    CNTL_MOM = 2'b00,  // Middle of message
    CNTL_SOM = 2'b01,  // Start of message
    CNTL_EOM = 2'b10   // End of message
  } up_cntl_t;

  // Only the first beat carries the data type
  typedef enum logic [1:0] {
    TYPE_NA   = 2'b00,
    TYPE_DATA = 2'b01
  } up_type_t;

  // One bus beat as stored in the FIFO
  typedef struct packed {
    up_cntl_t                  cntl;
    up_type_t                  ptype;
    logic [UP_DATA_WIDTH-1:0]  data;
    logic [UP_TAG_WIDTH-1:0]   oob_data;
  } up_beat_t;

endpackage

/* simd_lane_pkg.sv */
// SIMD execution lane definitions
// Lane word and tag types, lanes per bus beat and the beat count helper

package simd_lane_pkg;

  import stack_up_pkg::*;

  // --------------------------------------------------
  // Lane word
  // --------------------------------------------------
  localparam int LANE_WIDTH = 32;

  typedef logic [LANE_WIDTH-1:0] lane_word_t;

  // Tag travels unchanged as out-of-band data
  typedef logic [UP_TAG_WIDTH-1:0] tag_t;

  // Lanes packed into one upstream beat
  localparam int LANES_PER_BEAT = UP_DATA_WIDTH / LANE_WIDTH;

  // Beats needed to carry a whole lane bank
  function automatic int beat_count(input int num_lanes);
    return num_lanes / LANES_PER_BEAT;
  endfunction

endpackage

/* lane_capture.sv */
// SIMD lane capture
// Registers the lane bank and valids, holds tag and lane count, builds the lane mask
`timescale 1ns/100ps

module lane_capture
  import simd_lane_pkg::*;
#(
  parameter int NUM_LANES = 8
)
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [NUM_LANES-1:0]           regs_valid,
  input  lane_word_t                     regs [NUM_LANES],
  input  tag_t                           tag,
  input  logic [$clog2(NUM_LANES+1)-1:0] tag_num_lanes,
  output lane_word_t                     lane_words [NUM_LANES],
  output logic                           any_valid,
  output tag_t                           held_tag,
  output logic [NUM_LANES-1:0]           lane_enable
);

  logic [NUM_LANES-1:0]           valid_q;
  logic [$clog2(NUM_LANES+1)-1:0] num_lanes_q;
  logic                           raw_valid;

  assign raw_valid = |regs_valid;

  // --------------------------------------------------
  // Input registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= '0;
    else
      valid_q <= regs_valid;
  end

  always_ff @(posedge clk)
  begin
    lane_words <= regs;  // Sampled every cycle
  end

  // Tag and count only follow the SIMD while it presents data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      num_lanes_q <= '0;
    else if (raw_valid)
      num_lanes_q <= tag_num_lanes;
  end

  always_ff @(posedge clk)
  begin
    if (raw_valid)
      held_tag <= tag;
  end

  // Lanes at or above the active count are masked
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      lane_enable[i] = (i < int'(num_lanes_q));
  end

  assign any_valid = |valid_q;

endmodule

/* pipelined_fifo.sv */
// Pipelined FIFO with prefetched head
// Circular buffer feeding an output register with an almost full threshold
`timescale 1ns/100ps

module pipelined_fifo #(
  parameter int  FIFO_DEPTH     = 8,
  parameter int  FIFO_THRESHOLD = 6,
  parameter type payload_t      = logic [7:0]
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     write,
  input  payload_t write_data,
  input  logic     pipe_read,
  output logic     almost_full,
  output logic     pipe_valid,
  output payload_t pipe_data
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // Entries in mem without the head register
  logic             push;
  logic             load;    // Move oldest entry into head register

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push        = write && (count != CNT_W'(FIFO_DEPTH));
  assign load        = (count != '0) && (!pipe_valid || pipe_read);
  assign almost_full = (count >= CNT_W'(FIFO_THRESHOLD));

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= write_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (load)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push, load})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // --------------------------------------------------
  // Head register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pipe_valid <= 1'b0;
    else if (load)
      pipe_valid <= 1'b1;
    else if (pipe_read)
      pipe_valid <= 1'b0;  // Drained with nothing behind it
  end

  always_ff @(posedge clk)
  begin
    if (load)
      pipe_data <= mem[rd_ptr];
  end

endmodule

/* upstream_packetizer.sv */
// Upstream packetizer
// Cuts the captured lane bank into framed bus beats and drives the SIMD status flags
`timescale 1ns/100ps

module upstream_packetizer
  import stack_up_pkg::*;
  import simd_lane_pkg::*;
#(
  parameter int NUM_LANES = 8
)
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  lane_word_t           lane_words [NUM_LANES],
  input  logic [NUM_LANES-1:0] lane_enable,
  input  logic                 any_valid,
  input  tag_t                 held_tag,
  input  logic                 almost_full,
  output logic                 beat_write,
  output up_beat_t             beat,
  output logic                 regs_complete,
  output logic                 regs_ready
);

  localparam int NUM_BEATS = beat_count(NUM_LANES);
  localparam int CNT_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MID,
    ST_END,
    ST_COMPLETE
  } state_t;

  state_t           state;
  state_t           state_nxt;
  logic [CNT_W-1:0] beat_cnt;   // Index of the beat being written
  logic             ready_q;

  // --------------------------------------------------
  // Framing FSM
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (any_valid && !almost_full)
          state_nxt = (NUM_BEATS > 1) ? ST_MID : ST_END;
      ST_MID:
        if (!almost_full && (beat_cnt == CNT_W'(NUM_BEATS - 2)))
          state_nxt = ST_END;  // Last middle beat going out
      ST_END:
        if (!almost_full)
          state_nxt = ST_COMPLETE;
      ST_COMPLETE:
        if (!any_valid)
          state_nxt = ST_IDLE;  // SIMD has released the bank
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // Stall, never drop, while the FIFO is nearly full
  assign beat_write = ((state == ST_MID) || (state == ST_END)) && !almost_full;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      beat_cnt <= '0;
    else if (state == ST_IDLE)
      beat_cnt <= '0;
    else if (beat_write)
      beat_cnt <= (state == ST_END) ? '0 : beat_cnt + 1'b1;
  end

  // --------------------------------------------------
  // Beat assembly
  // --------------------------------------------------
  always_comb
  begin : beat_mux
    int lane_idx;
    beat.data = '0;
    for (int j = 0; j < LANES_PER_BEAT; j++)
    begin
      lane_idx = int'(beat_cnt) * LANES_PER_BEAT + j;
      if (lane_enable[lane_idx])
        beat.data[j*LANE_WIDTH +: LANE_WIDTH] = lane_words[lane_idx];
    end
    if (beat_cnt == '0)
      beat.cntl = CNTL_SOM;
    else if (beat_cnt == CNT_W'(NUM_BEATS - 1))
      beat.cntl = CNTL_EOM;
    else
      beat.cntl = CNTL_MOM;
    beat.ptype    = (beat_cnt == '0) ? TYPE_DATA : TYPE_NA;
    beat.oob_data = held_tag;
  end

  // --------------------------------------------------
  // SIMD status
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ready_q <= 1'b0;
    else
      ready_q <= (state == ST_IDLE);
  end

  assign regs_ready    = ready_q;
  assign regs_complete = (state == ST_COMPLETE);  // Held until valids drop

endmodule

/* simd_upstream_intf.sv */
// SIMD to upstream bus adapter
// Captures the SIMD lane bank, packetizes it and queues beats for the upstream bus
`timescale 1ns/100ps

module simd_upstream_intf
  import stack_up_pkg::*;
  import simd_lane_pkg::*;
#(
  parameter int NUM_LANES      = 8,
  parameter int FIFO_DEPTH     = 8,
  parameter int FIFO_THRESHOLD = 6
)
(
  input  logic                           clk,
  input  logic                           rst_n,
  // SIMD side
  input  logic [NUM_LANES-1:0]           regs_valid,
  input  lane_word_t                     regs [NUM_LANES],
  input  logic [UP_TAG_WIDTH-1:0]        tag,
  input  logic [$clog2(NUM_LANES+1)-1:0] tag_num_lanes,
  output logic                           regs_complete,
  output logic                           regs_ready,
  // Upstream bus
  input  logic                           up_ready,
  output logic                           up_valid,
  output up_cntl_t                       up_cntl,
  output up_type_t                       up_type,
  output logic [UP_DATA_WIDTH-1:0]       up_data,
  output logic [UP_TAG_WIDTH-1:0]        up_oob_data
);

  lane_word_t           lane_words [NUM_LANES];
  logic                 any_valid;
  tag_t                 held_tag;
  logic [NUM_LANES-1:0] lane_enable;
  logic                 beat_write;
  up_beat_t             beat;
  logic                 almost_full;
  logic                 pipe_valid;
  logic                 pipe_read;
  up_beat_t             pipe_beat;
  logic                 ready_d1;

  lane_capture #(.NUM_LANES(NUM_LANES)) u_capture (
    .clk(clk), .rst_n(rst_n),
    .regs_valid(regs_valid), .regs(regs), .tag(tag), .tag_num_lanes(tag_num_lanes),
    .lane_words(lane_words), .any_valid(any_valid), .held_tag(held_tag),
    .lane_enable(lane_enable)
  );

  upstream_packetizer #(.NUM_LANES(NUM_LANES)) u_packetizer (
    .clk(clk), .rst_n(rst_n),
    .lane_words(lane_words), .lane_enable(lane_enable), .any_valid(any_valid),
    .held_tag(held_tag), .almost_full(almost_full),
    .beat_write(beat_write), .beat(beat),
    .regs_complete(regs_complete), .regs_ready(regs_ready)
  );

  pipelined_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH), .FIFO_THRESHOLD(FIFO_THRESHOLD), .payload_t(up_beat_t)
  ) u_fifo (
    .clk(clk), .rst_n(rst_n),
    .write(beat_write), .write_data(beat), .pipe_read(pipe_read),
    .almost_full(almost_full), .pipe_valid(pipe_valid), .pipe_data(pipe_beat)
  );

  // --------------------------------------------------
  // Bus side
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ready_d1 <= 1'b0;
    else
      ready_d1 <= up_ready;
  end

  assign pipe_read   = ready_d1 && pipe_valid;  // Pop only on last cycle's ready
  assign up_valid    = pipe_read;
  assign up_cntl     = pipe_beat.cntl;
  assign up_type     = pipe_beat.ptype;
  assign up_data     = pipe_beat.data;
  assign up_oob_data = pipe_beat.oob_data;

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset source
// Free running clock, reset held low for a set number of cycles
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real PERIOD_NS    = 10.0,
  parameter int  RESET_CYCLES = 16
)
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;  // Release between active edges
  end

endmodule

/* simd_upstream_intf_props.sv */
// Upstream bus protocol checks
// Bound into the adapter top level, watches the bus and the SIMD status flags
`timescale 1ns/100ps

module simd_upstream_intf_props
  import stack_up_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     up_ready,
  input logic     up_valid,
  input up_cntl_t up_cntl,
  input up_type_t up_type,
  input logic     regs_complete,
  input logic     regs_ready
);

  logic in_msg;  // Between SOM and EOM

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      in_msg <= 1'b0;
    else if (up_valid && (up_cntl == CNTL_EOM))
      in_msg <= 1'b0;
    else if (up_valid && (up_cntl == CNTL_SOM))
      in_msg <= 1'b1;
  end

  // --------------------------------------------------
  // Bus rules
  // --------------------------------------------------
  ready_before_valid: assert property (@(posedge clk) disable iff (!rst_n)
    up_valid |-> $past(up_ready))
    else $error("up_valid without up_ready in the previous cycle");

  som_opens_message: assert property (@(posedge clk) disable iff (!rst_n)
    (up_valid && (up_cntl == CNTL_SOM)) |-> (!in_msg && (up_type == TYPE_DATA)))
    else $error("start of message inside a message or without data type");

  beat_inside_message: assert property (@(posedge clk) disable iff (!rst_n)
    (up_valid && (up_cntl != CNTL_SOM)) |-> in_msg)
    else $error("middle or end beat outside a message");

  status_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(regs_complete && regs_ready))
    else $error("regs_complete and regs_ready high together");

endmodule

bind simd_upstream_intf simd_upstream_intf_props u_props (
  .clk(clk), .rst_n(rst_n), .up_ready(up_ready), .up_valid(up_valid),
  .up_cntl(up_cntl), .up_type(up_type),
  .regs_complete(regs_complete), .regs_ready(regs_ready)
);

/* tb_simd_upstream_intf.sv */
// Testbench for the SIMD to upstream bus adapter
// Replays the message trace and checks every beat on the upstream bus
`timescale 1ns/100ps

module tb_simd_upstream_intf
  import stack_up_pkg::*;
  import simd_lane_pkg::*;
();

  localparam int NUM_LANES      = 8;
  localparam int NUM_BEATS      = NUM_LANES / LANES_PER_BEAT;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int IDLE_GAP       = 4;  // Quiet cycles after each message

  typedef enum {W_COMPLETE_HI, W_COMPLETE_LO, W_READY_HI, W_BEATS} wait_t;

  logic                           clk;
  logic                           rst_n;
  logic [NUM_LANES-1:0]           regs_valid;
  lane_word_t                     regs [NUM_LANES];
  logic [UP_TAG_WIDTH-1:0]        tag;
  logic [$clog2(NUM_LANES+1)-1:0] tag_num_lanes;
  logic                           regs_complete;
  logic                           regs_ready;
  logic                           up_ready;
  logic                           up_valid;
  up_cntl_t                       up_cntl;
  up_type_t                       up_type;
  logic [UP_DATA_WIDTH-1:0]       up_data;
  logic [UP_TAG_WIDTH-1:0]        up_oob_data;

  // Current trace line
  int                             t_mode;
  logic [UP_TAG_WIDTH-1:0]        t_tag;
  logic [$clog2(NUM_LANES+1)-1:0] t_count;
  lane_word_t                     t_lanes [NUM_LANES];
  logic [UP_DATA_WIDTH-1:0]       t_beats [NUM_BEATS];

  logic        random_ready = 1'b0;
  logic [31:0] rng          = 32'd24;  // LCG state
  logic        ready_prev   = 1'b0;
  up_beat_t    got_q [$];
  int          errors       = 0;
  int          tests        = 0;
  int          failed       = 0;
  int          timeouts     = 0;
  logic        bad_trace    = 1'b0;

  tb_clk_gen #(.PERIOD_NS(10.0), .RESET_CYCLES(16)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  simd_upstream_intf #(
    .NUM_LANES(NUM_LANES), .FIFO_DEPTH(8), .FIFO_THRESHOLD(6)
  ) u_dut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic logic condition_met(input wait_t what);
    case (what)
      W_COMPLETE_HI: return regs_complete;
      W_COMPLETE_LO: return !regs_complete;
      W_READY_HI:    return regs_ready;
      default:       return got_q.size() >= NUM_BEATS;
    endcase
  endfunction

  // Steps to just after each falling edge
  task automatic wait_until(input wait_t what, input string name);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk);
      #1;
      cycles++;
    end
    while (!condition_met(what) && cycles < TIMEOUT_CYCLES);
    if (!condition_met(what))
    begin
      $display("Timeout: %s did not happen within %0d cycles", name, TIMEOUT_CYCLES);
      timeouts++;
    end
  endtask

  // --------------------------------------------------
  // Bus side
  // --------------------------------------------------
  always @(posedge clk)
  begin
    if (random_ready)
    begin
      rng = lcg_next(rng);
      up_ready <= rng[28];
    end
    else
      up_ready <= 1'b1;
  end

  always @(negedge clk)
  begin : monitor
    up_beat_t seen;
    if (up_valid)
    begin
      assert (ready_prev)
        else report_error("beat offered without up_ready in the previous cycle");
      seen.cntl     = up_cntl;
      seen.ptype    = up_type;
      seen.data     = up_data;
      seen.oob_data = up_oob_data;
      got_q.push_back(seen);
    end
    ready_prev = up_ready;
  end

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic check_reset();
    int cycles;
    int err_before;
    cycles     = 0;
    err_before = errors;
    tests++;
    @(negedge clk);
    while (!rst_n && cycles < TIMEOUT_CYCLES)
    begin
      assert (!up_valid && !regs_complete && !regs_ready)
        else report_error("control outputs active during reset");
      @(negedge clk);
      cycles++;
    end
    if (!rst_n)
    begin
      $display("Timeout: reset was never released");
      timeouts++;
    end
    wait_until(W_READY_HI, "regs_ready after reset");
    assert (!up_valid && !regs_complete)
      else report_error("up_valid or regs_complete set after reset");
    if (errors != err_before || timeouts != 0)
      failed++;
    $display("Test %0d reset: %s", tests,
             (errors != err_before || timeouts != 0) ? "FAIL" : "PASS");
  endtask

  task automatic run_message();
    up_cntl_t exp_cntl;
    up_type_t exp_type;
    up_beat_t seen;
    tests++;
    got_q.delete();
    random_ready = (t_mode != 0);
    @(posedge clk);
    for (int i = 0; i < NUM_LANES; i++)
      regs[i] <= t_lanes[i];
    tag           <= t_tag;
    tag_num_lanes <= t_count;
    regs_valid    <= '1;
    wait_until(W_COMPLETE_HI, "regs_complete");
    if (timeouts != 0)
      return;
    @(posedge clk);
    regs_valid <= '0;
    @(negedge clk);
    assert (regs_complete) else report_error("regs_complete fell before valids dropped");
    wait_until(W_COMPLETE_LO, "regs_complete release");
    wait_until(W_READY_HI, "regs_ready after the message");
    wait_until(W_BEATS, "arrival of all beats");
    if (timeouts != 0)
      return;
    repeat (IDLE_GAP) @(negedge clk);
    #1;
    assert (got_q.size() == NUM_BEATS)
      else report_error($sformatf("expected %0d beats, got %0d", NUM_BEATS, got_q.size()));
    for (int k = 0; k < NUM_BEATS && k < got_q.size(); k++)
    begin
      seen     = got_q[k];
      exp_cntl = (k == 0) ? CNTL_SOM : ((k == NUM_BEATS - 1) ? CNTL_EOM : CNTL_MOM);
      exp_type = (k == 0) ? TYPE_DATA : TYPE_NA;
      assert (seen.cntl == exp_cntl)
        else report_error($sformatf("beat %0d frame code %s", k, seen.cntl.name()));
      assert (seen.ptype == exp_type)
        else report_error($sformatf("beat %0d type %s", k, seen.ptype.name()));
      assert (seen.data == t_beats[k])
        else report_error($sformatf("beat %0d data %h, expected %h", k, seen.data, t_beats[k]));
      assert (seen.oob_data == t_tag)
        else report_error($sformatf("beat %0d oob %h, expected %h", k, seen.oob_data, t_tag));
    end
  endtask

  initial
  begin : main
    int    fd;
    int    n;
    int    err_before;
    string line;
    regs_valid    = '0;
    tag           = '0;
    tag_num_lanes = '0;
    up_ready      = 1'b0;
    for (int i = 0; i < NUM_LANES; i++)
      regs[i] = '0;
    check_reset();
    fd = $fopen("sui_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file sui_trace.txt");
      bad_trace = 1'b1;
    end
    while (fd != 0 && !$feof(fd) && timeouts == 0 && !bad_trace)
    begin
      line = "";
      n    = $fgets(line, fd);
      if (n > 1 && line[0] != "/")
      begin
        n = $sscanf(line, "%d %h %d %h %h %h %h %h %h %h %h %h %h %h %h",
                    t_mode, t_tag, t_count,
                    t_lanes[0], t_lanes[1], t_lanes[2], t_lanes[3],
                    t_lanes[4], t_lanes[5], t_lanes[6], t_lanes[7],
                    t_beats[0], t_beats[1], t_beats[2], t_beats[3]);
        if (n != 15)
        begin
          $display("Trace line could not be read: %s", line);
          bad_trace = 1'b1;
        end
        else
        begin
          err_before = errors;
          run_message();
          if (errors != err_before || timeouts != 0)
            failed++;
          $display("Test %0d tag %h, %0d lanes, %s ready: %s", tests, t_tag, t_count,
                   (t_mode != 0) ? "random" : "steady",
                   (errors != err_before || timeouts != 0) ? "FAIL" : "PASS");
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
    $display("Tests %0d, failed %0d, errors %0d, timeouts %0d",
             tests, failed, errors, timeouts);
    if (errors == 0 && timeouts == 0 && failed == 0 && !bad_trace)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* sui_trace.txt */
// mode tag count lane0..lane7 then beat0..beat3, all hex except mode and count
// mode 0 holds up_ready high, mode 1 drives it from the LCG; beat k = {lane 2k+1, lane 2k}
0 a501 8 1101 1102 1103 1104 1105 1106 1107 1108 110200001101 110400001103 110600001105 110800001107
0 a502 3 2201 2202 2203 2204 2205 2206 2207 2208 220200002201 2203 0 0
1 a503 8 3301 3302 3303 3304 3305 3306 3307 3308 330200003301 330400003303 330600003305 330800003307
1 a504 8 f00d beef cafe dead 0001 8000 7fff ffff beef0000f00d dead0000cafe 800000000001 ffff00007fff
0 0b05 5 5501 5502 5503 5504 5505 5506 5507 5508 550200005501 550400005503 5505 0
1 0b06 1 6601 6602 6603 6604 6605 6606 6607 6608 6601 0 0 0
0 c007 7 7701 7702 7703 7704 7705 7706 7707 7708 770200007701 770400007703 770600007705 7707
1 c008 2 8801 8802 8803 8804 8805 8806 8807 8808 880200008801 0 0 0
0 d009 8 9901 9902 9903 9904 9905 9906 9907 9908 990200009901 990400009903 990600009905 990800009907
1 d00a 4 aa01 aa02 aa03 aa04 aa05 aa06 aa07 aa08 aa020000aa01 aa040000aa03 0 0
1 e00b 6 bb01 bb02 bb03 bb04 bb05 bb06 bb07 bb08 bb020000bb01 bb040000bb03 bb060000bb05 0
0 e00c 2 12345678 9abcdef0 0bad 0bad 0bad 0bad 0bad 0bad 9abcdef012345678 0 0 0

/* flist.f */
stack_up_pkg.sv
simd_lane_pkg.sv
lane_capture.sv
pipelined_fifo.sv
upstream_packetizer.sv
simd_upstream_intf.sv
tb_clk_gen.sv
simd_upstream_intf_props.sv
tb_simd_upstream_intf.sv

/* Bender.yml */
package:
  name: simd_upstream_intf

sources:
  # Design, in compile order
  - stack_up_pkg.sv
  - simd_lane_pkg.sv
  - lane_capture.sv
  - pipelined_fifo.sv
  - upstream_packetizer.sv
  - simd_upstream_intf.sv
  # Testbench
  - target: simulation
    files:
      - tb_clk_gen.sv
      - simd_upstream_intf_props.sv
      - tb_simd_upstream_intf.sv
